/* hw/cachePkg.sv */
package cachePkg;

    // address layout, one 64-bit word per line
    localparam int addrWidth   = 32;
    localparam int dataWidth   = 64;
    localparam int offsetWidth = 3;
    localparam int indexWidth  = 2;
    localparam int tagWidth    = addrWidth - indexWidth - offsetWidth;
    localparam int numSets     = 2 ** indexWidth;
    localparam int numWays     = 2;

    typedef struct packed {
        logic [tagWidth-1:0]    tag;
        logic [indexWidth-1:0]  index;
        logic [offsetWidth-1:0] offset;
    } cacheAddrFields_t;

    // same address word, seen raw or split into fields
    typedef union packed {
        logic [addrWidth-1:0] raw;
        cacheAddrFields_t     fields;
    } cacheAddr_u;

    typedef struct packed {
        logic                 hit;
        logic [dataWidth-1:0] data;
    } lookup_t;

    typedef struct packed {
        logic                   rdStrobe;
        logic                   wrStrobe;
        logic [addrWidth-1:0]   addr;
        logic [dataWidth-1:0]   wdata;
        logic [dataWidth/8-1:0] mask;
    } memReq_t;

    typedef struct packed {
        logic enable;
        logic flush;
    } cacheCtl_t;

endpackage

/* hw/cacheArray.sv */
`timescale 1ns/1ps

module cacheArray import cachePkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  cacheAddr_u             lookupAddr,
    input  logic                   fill,
    input  cacheAddr_u             fillAddr,
    input  logic [dataWidth-1:0]   fillData,
    input  logic                   write,
    input  cacheAddr_u             writeAddr,
    input  logic [dataWidth-1:0]   writeData,
    input  logic [dataWidth/8-1:0] writeMask,
    input  cacheCtl_t              ctl,
    output lookup_t                lookup
);

    logic [dataWidth-1:0] dataMem [numWays][numSets];
    logic [tagWidth-1:0]  tagMem [numWays][numSets];
    logic [numWays-1:0]   validMem [numSets];
    // one round-robin bit per set picks the next victim way
    logic [numSets-1:0]   rrPtr;

    logic [numWays-1:0]    lookupHit;
    logic [numWays-1:0]    writeHit;
    logic [indexWidth-1:0] fillIdx;
    logic [indexWidth-1:0] writeIdx;
    logic                  victim;

    function automatic logic [numWays-1:0] matchWays(input cacheAddr_u a);
        logic [numWays-1:0] m;
        for (int w = 0; w < numWays; w++) begin
            m[w] = validMem[a.fields.index][w]
                && (tagMem[w][a.fields.index] == a.fields.tag);
        end
        return m;
    endfunction

    assign lookupHit = matchWays(lookupAddr);
    assign writeHit  = matchWays(writeAddr);
    assign fillIdx   = fillAddr.fields.index;
    assign writeIdx  = writeAddr.fields.index;
    assign victim    = rrPtr[fillIdx];

    always_comb begin
        lookup.hit  = |lookupHit;
        lookup.data = '0;
        for (int w = 0; w < numWays; w++) begin
            if (lookupHit[w]) begin
                lookup.data = dataMem[w][lookupAddr.fields.index];
            end
        end
    end

    // valid bits and pointers, flush drops everything at once
    always_ff @(posedge clk) begin
        if (rst || ctl.flush) begin
            validMem <= '{default: '0};
            rrPtr    <= '0;
        end else if (fill) begin
            validMem[fillIdx][victim] <= 1'b1;
            rrPtr[fillIdx]            <= ~victim;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            dataMem[victim][fillIdx] <= fillData;
            tagMem[victim][fillIdx]  <= fillAddr.fields.tag;
        end
        // byte merge into the way that hits, no allocation on a miss
        if (write) begin
            for (int w = 0; w < numWays; w++) begin
                for (int b = 0; b < dataWidth / 8; b++) begin
                    if (writeHit[w] && writeMask[b]) begin
                        dataMem[w][writeIdx][b*8 +: 8] <= writeData[b*8 +: 8];
                    end
                end
            end
        end
    end

    // a fill only happens while the controller waits on memory
    fillWriteExclusive: assert property (
        @(posedge clk) disable iff (rst) !(fill && write)
    );

    // fills go only to missing lines, so a tag never lives in both ways
    singleWayHit: assert property (
        @(posedge clk) disable iff (rst) $onehot0(lookupHit)
    );

endmodule

/* hw/cacheCtrl.sv */
`timescale 1ns/1ps

module cacheCtrl import cachePkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   readReq,
    input  cacheAddr_u             readAddr,
    input  logic                   writeReq,
    input  cacheAddr_u             writeAddr,
    input  logic [dataWidth-1:0]   writeData,
    input  logic [dataWidth/8-1:0] writeMask,
    input  cacheCtl_t              ctl,
    input  lookup_t                lookup,
    input  logic                   memRespValid,
    input  logic [dataWidth-1:0]   memRespData,
    output logic                   readValid,
    output logic [dataWidth-1:0]   readData,
    output logic                   busy,
    output memReq_t                memReq,
    output cacheAddr_u             lookupAddr,
    output logic                   fill,
    output cacheAddr_u             fillAddr,
    output logic [dataWidth-1:0]   fillData,
    output logic                   arrWrite,
    output cacheAddr_u             arrWriteAddr,
    output logic [dataWidth-1:0]   arrWriteData,
    output logic [dataWidth/8-1:0] arrWriteMask,
    output logic                   hitEvent,
    output logic                   missEvent
);

    // sequencer state, low is idle, high is waiting for memory
    logic       waitMem;
    logic       fillPending;
    cacheAddr_u pendingAddr;

    logic readHit;
    logic readMiss;
    logic respTaken;

    logic                   memRd;
    logic                   memWr;
    logic [addrWidth-1:0]   memAddr;
    logic [dataWidth-1:0]   memWdata;
    logic [dataWidth/8-1:0] memMask;

    assign lookupAddr = readAddr;
    assign readHit    = readReq && !waitMem && ctl.enable && lookup.hit;
    assign readMiss   = readReq && !waitMem && !readHit;
    assign respTaken  = waitMem && memRespValid;

    // counters see the event on the edge that launches readValid
    assign hitEvent  = readHit;
    assign missEvent = respTaken;

    // refill only for misses taken while enabled
    assign fill     = respTaken && fillPending && ctl.enable;
    assign fillAddr = pendingAddr;
    assign fillData = memRespData;

    // write hits merge in the array, gated by enable
    assign arrWrite     = writeReq && ctl.enable;
    assign arrWriteAddr = writeAddr;
    assign arrWriteData = writeData;
    assign arrWriteMask = writeMask;

    assign busy = waitMem;

    always_ff @(posedge clk) begin
        if (rst) begin
            waitMem   <= 1'b0;
            readValid <= 1'b0;
            memRd     <= 1'b0;
            memWr     <= 1'b0;
        end else begin
            readValid <= readHit || respTaken;
            memRd     <= readMiss;
            memWr     <= writeReq;
            if (readMiss) begin
                waitMem <= 1'b1;
            end else if (respTaken) begin
                waitMem <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (readHit) begin
            readData <= lookup.data;
        end else if (respTaken) begin
            readData <= memRespData;
        end
        if (readMiss) begin
            pendingAddr <= readAddr;
            fillPending <= ctl.enable;
        end
    end

    // memory payload, held until the next strobe
    always_ff @(posedge clk) begin
        if (readMiss) begin
            memAddr <= readAddr.raw;
        end else if (writeReq) begin
            memAddr  <= writeAddr.raw;
            memWdata <= writeData;
            memMask  <= writeMask;
        end
    end

    assign memReq = '{
        rdStrobe: memRd,
        wrStrobe: memWr,
        addr:     memAddr,
        wdata:    memWdata,
        mask:     memMask
    };

    noReqWhileBusy: assert property (
        @(posedge clk) disable iff (rst) busy |-> !(readReq || writeReq)
    );

    noReadWithWrite: assert property (
        @(posedge clk) disable iff (rst) !(readReq && writeReq)
    );

    noRespWhenIdle: assert property (
        @(posedge clk) disable iff (rst) !waitMem |-> !memRespValid
    );

endmodule

/* hw/cacheCsr.sv */
`timescale 1ns/1ps

module cacheCsr import cachePkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        csrWrite,
    input  logic [1:0]  csrAddr,
    input  logic [31:0] csrWdata,
    input  logic        hitEvent,
    input  logic        missEvent,
    output logic [31:0] csrRdata,
    output cacheCtl_t   ctl
);

    // counts[0] holds hits, counts[1] holds misses
    logic [31:0] counts [2];
    logic [1:0]  events;
    logic        ctlWrite;

    assign events   = {missEvent, hitEvent};
    assign ctlWrite = csrWrite && (csrAddr == 2'd0);

    always_ff @(posedge clk) begin
        if (rst) begin
            ctl <= '0;
        end else begin
            // flush lasts exactly one cycle
            ctl.flush <= ctlWrite && csrWdata[1];
            if (ctlWrite) begin
                ctl.enable <= csrWdata[0];
            end
        end
    end

    // any write to a counter register clears it
    always_ff @(posedge clk) begin
        if (rst) begin
            counts <= '{default: '0};
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (csrWrite && (csrAddr == 2'(i + 1))) begin
                    counts[i] <= '0;
                end else if (events[i]) begin
                    counts[i] <= counts[i] + 32'd1;
                end
            end
        end
    end

    always_comb begin
        case (csrAddr)
            2'd0: begin
                csrRdata = {31'b0, ctl.enable};
            end
            2'd1: begin
                csrRdata = counts[0];
            end
            2'd2: begin
                csrRdata = counts[1];
            end
            default: begin
                csrRdata = '0;
            end
        endcase
    end

endmodule

/* hw/cacheTop.sv */
`timescale 1ns/1ps

module cacheTop import cachePkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   readReq,
    input  cacheAddr_u             readAddr,
    input  logic                   writeReq,
    input  cacheAddr_u             writeAddr,
    input  logic [dataWidth-1:0]   writeData,
    input  logic [dataWidth/8-1:0] writeMask,
    output logic                   readValid,
    output logic [dataWidth-1:0]   readData,
    output logic                   busy,
    output memReq_t                memReq,
    input  logic                   memRespValid,
    input  logic [dataWidth-1:0]   memRespData,
    input  logic                   csrWrite,
    input  logic [1:0]             csrAddr,
    input  logic [31:0]            csrWdata,
    output logic [31:0]            csrRdata
);

    // controller to array
    cacheAddr_u             lookupAddr;
    logic                   fill;
    cacheAddr_u             fillAddr;
    logic [dataWidth-1:0]   fillData;
    logic                   arrWrite;
    cacheAddr_u             arrWriteAddr;
    logic [dataWidth-1:0]   arrWriteData;
    logic [dataWidth/8-1:0] arrWriteMask;
    lookup_t                lookup;

    // register block side
    cacheCtl_t ctl;
    logic      hitEvent;
    logic      missEvent;

    cacheCtrl ctrl0 (
        .clk          (clk),
        .rst          (rst),
        .readReq      (readReq),
        .readAddr     (readAddr),
        .writeReq     (writeReq),
        .writeAddr    (writeAddr),
        .writeData    (writeData),
        .writeMask    (writeMask),
        .ctl          (ctl),
        .lookup       (lookup),
        .memRespValid (memRespValid),
        .memRespData  (memRespData),
        .readValid    (readValid),
        .readData     (readData),
        .busy         (busy),
        .memReq       (memReq),
        .lookupAddr   (lookupAddr),
        .fill         (fill),
        .fillAddr     (fillAddr),
        .fillData     (fillData),
        .arrWrite     (arrWrite),
        .arrWriteAddr (arrWriteAddr),
        .arrWriteData (arrWriteData),
        .arrWriteMask (arrWriteMask),
        .hitEvent     (hitEvent),
        .missEvent    (missEvent)
    );

    cacheArray array0 (
        .clk        (clk),
        .rst        (rst),
        .lookupAddr (lookupAddr),
        .fill       (fill),
        .fillAddr   (fillAddr),
        .fillData   (fillData),
        .write      (arrWrite),
        .writeAddr  (arrWriteAddr),
        .writeData  (arrWriteData),
        .writeMask  (arrWriteMask),
        .ctl        (ctl),
        .lookup     (lookup)
    );

    cacheCsr csr0 (
        .clk       (clk),
        .rst       (rst),
        .csrWrite  (csrWrite),
        .csrAddr   (csrAddr),
        .csrWdata  (csrWdata),
        .hitEvent  (hitEvent),
        .missEvent (missEvent),
        .csrRdata  (csrRdata),
        .ctl       (ctl)
    );

endmodule

/* verif/memPattern.svh */
// power-on memory content, every address bit reaches the word
function automatic logic [63:0] initialWord(input logic [31:0] addr);
    return {addr ^ 32'hc3a5_5a3c, ~{addr[15:0], addr[31:16]}};
endfunction

// address of the aligned 64-bit word
function automatic logic [31:0] wordAddr(input logic [31:0] addr);
    return {addr[31:3], 3'b000};
endfunction

// replace only the bytes whose mask bit is set
function automatic logic [63:0] mergeBytes(
    input logic [63:0] oldWord,
    input logic [63:0] newWord,
    input logic [7:0]  mask
);
    logic [63:0] merged;
    merged = oldWord;
    for (int b = 0; b < 8; b++) begin
        if (mask[b]) begin
            merged[b*8 +: 8] = newWord[b*8 +: 8];
        end
    end
    return merged;
endfunction

/* verif/cacheChecker.sv */
`timescale 1ns/1ps

module cacheChecker import cachePkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   readReq,
    input  cacheAddr_u             readAddr,
    input  logic                   writeReq,
    input  cacheAddr_u             writeAddr,
    input  logic [dataWidth-1:0]   writeData,
    input  logic [dataWidth/8-1:0] writeMask,
    input  logic                   readValid,
    input  logic [dataWidth-1:0]   readData,
    input  logic                   busy,
    input  memReq_t                memReq,
    input  logic                   memRespValid,
    input  logic                   csrWrite,
    input  logic [1:0]             csrAddr,
    input  logic [31:0]            csrWdata,
    input  logic [31:0]            csrRdata,
    input  logic                   csrCheck,
    input  logic [31:0]            csrExpected,
    output int                     errorCount,
    output int                     checkCount
);

    `include "memPattern.svh"

    logic [dataWidth-1:0] shadow [logic [addrWidth-1:0]];

    // cache model, data itself comes from the shadow memory
    logic [tagWidth-1:0] tagModel [numSets][numWays];
    logic [numWays-1:0]  validModel [numSets];
    logic [numSets-1:0]  rrModel;
    logic                enableModel;
    int                  hitModel;
    int                  missModel;

    // what the DUT owes on the next edge
    logic                   validDue;
    logic                   rdDue;
    logic                   wrDue;
    logic                   missWaiting;
    logic [dataWidth-1:0]   expData;
    logic [addrWidth-1:0]   expRdAddr;
    logic [addrWidth-1:0]   expWrAddr;
    logic [dataWidth-1:0]   expWrData;
    logic [dataWidth/8-1:0] expWrMask;

    function automatic logic [dataWidth-1:0] shadowWord(input logic [addrWidth-1:0] a);
        if (shadow.exists(wordAddr(a))) begin
            return shadow[wordAddr(a)];
        end
        return initialWord(wordAddr(a));
    endfunction

    task automatic compare(input string name, input logic [63:0] expVal,
                           input logic [63:0] gotVal);
        checkCount++;
        if (expVal !== gotVal) begin
            errorCount++;
            $display("mismatch %s expected %h got %h at %0t", name, expVal, gotVal, $time);
        end
    endtask

    initial begin
        errorCount = 0;
        checkCount = 0;
    end

    always @(posedge clk) begin
        cacheAddrFields_t f;
        logic             hitNow;
        logic [31:0]      csrModel;
        if (rst) begin
            validModel  = '{default: '0};
            rrModel     = '0;
            enableModel = 1'b0;
            hitModel    = 0;
            missModel   = 0;
            validDue    = 1'b0;
            rdDue       = 1'b0;
            wrDue       = 1'b0;
            missWaiting = 1'b0;
        end else begin
            compare("busy", missWaiting, busy);
            compare("readValid", validDue, readValid);
            if (validDue && readValid) begin
                compare("readData", expData, readData);
            end
            compare("memReq.rdStrobe", rdDue, memReq.rdStrobe);
            if (rdDue && memReq.rdStrobe) begin
                compare("memReq.addr", expRdAddr, memReq.addr);
            end
            compare("memReq.wrStrobe", wrDue, memReq.wrStrobe);
            if (wrDue && memReq.wrStrobe) begin
                compare("memReq.addr", expWrAddr, memReq.addr);
                compare("memReq.wdata", expWrData, memReq.wdata);
                compare("memReq.mask", expWrMask, memReq.mask);
            end

            // a pending miss ends with the memory response
            validDue = missWaiting && memRespValid;
            if (validDue) begin
                missWaiting = 1'b0;
            end
            rdDue = 1'b0;
            wrDue = writeReq;

            if (readReq) begin
                f      = readAddr.fields;
                hitNow = 1'b0;
                for (int w = 0; w < numWays; w++) begin
                    if (enableModel && validModel[f.index][w]
                        && tagModel[f.index][w] == f.tag) begin
                        hitNow = 1'b1;
                    end
                end
                expData = shadowWord(readAddr.raw);
                if (hitNow) begin
                    validDue = 1'b1;
                    hitModel++;
                end else begin
                    rdDue       = 1'b1;
                    missWaiting = 1'b1;
                    expRdAddr   = readAddr.raw;
                    missModel++;
                    // victim is the way the set pointer names
                    if (enableModel) begin
                        tagModel[f.index][rrModel[f.index]]   = f.tag;
                        validModel[f.index][rrModel[f.index]] = 1'b1;
                        rrModel[f.index] = ~rrModel[f.index];
                    end
                end
            end

            if (writeReq) begin
                shadow[wordAddr(writeAddr.raw)] =
                    mergeBytes(shadowWord(writeAddr.raw), writeData, writeMask);
                expWrAddr = writeAddr.raw;
                expWrData = writeData;
                expWrMask = writeMask;
            end

            if (csrCheck) begin
                case (csrAddr)
                    2'd0: csrModel = {31'b0, enableModel};
                    2'd1: csrModel = hitModel;
                    2'd2: csrModel = missModel;
                    default: csrModel = '0;
                endcase
                compare("csrRdata", csrExpected, csrRdata);
                compare("csrRdata (model)", csrModel, csrRdata);
            end

            if (csrWrite) begin
                if (csrAddr == 2'd0) begin
                    enableModel = csrWdata[0];
                    if (csrWdata[1]) begin
                        validModel = '{default: '0};
                        rrModel    = '0;
                    end
                end else if (csrAddr == 2'd1) begin
                    hitModel = 0;
                end else if (csrAddr == 2'd2) begin
                    missModel = 0;
                end
            end
        end
    end

endmodule

/* verif/cacheTb.sv */
`timescale 1ns/1ps

module cacheTb import cachePkg::*; ();

    `include "memPattern.svh"

    localparam int opRead      = 0;
    localparam int opWrite     = 1;
    localparam int opCsrWr     = 2;
    localparam int opCsrRd     = 3;
    localparam int cyclesPerOp = 60;

    typedef struct packed {
        logic [1:0]  kind;
        logic [31:0] addr;
        logic [63:0] data;
        logic [7:0]  mask;
        logic [31:0] expValue;
    } op_t;

    logic                   clk;
    logic                   rst;
    logic                   readReq;
    cacheAddr_u             readAddr;
    logic                   writeReq;
    cacheAddr_u             writeAddr;
    logic [dataWidth-1:0]   writeData;
    logic [dataWidth/8-1:0] writeMask;
    logic                   readValid;
    logic [dataWidth-1:0]   readData;
    logic                   busy;
    memReq_t                memReq;
    logic                   memRespValid;
    logic [dataWidth-1:0]   memRespData;
    logic                   csrWrite;
    logic [1:0]             csrAddr;
    logic [31:0]            csrWdata;
    logic [31:0]            csrRdata;
    logic                   csrCheck;
    logic [31:0]            csrExpected;
    int                     errorCount;
    int                     checkCount;

    op_t         ops[$];
    logic [63:0] mem [logic [31:0]];
    integer      seed = 8;
    int          cycleLimit;
    int          cycles;
    int          respWait;
    logic [31:0] respAddr;
    memReq_t     seenReq;

    cacheTop dut0 (.*);

    cacheChecker check0 (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [63:0] memWord(input logic [31:0] a);
        if (mem.exists(wordAddr(a))) begin
            return mem[wordAddr(a)];
        end
        return initialWord(wordAddr(a));
    endfunction

    // memory answers a read after 1 to 4 cycles
    initial begin
        memRespValid = 1'b0;
        memRespData  = '0;
        respWait     = 0;
        forever begin
            @(posedge clk);
            seenReq = memReq;
            #1;
            memRespValid = 1'b0;
            if (seenReq.wrStrobe) begin
                mem[wordAddr(seenReq.addr)] =
                    mergeBytes(memWord(seenReq.addr), seenReq.wdata, seenReq.mask);
            end
            if (respWait > 0) begin
                respWait--;
                if (respWait == 0) begin
                    memRespValid = 1'b1;
                    memRespData  = memWord(respAddr);
                end
            end
            if (seenReq.rdStrobe) begin
                respWait = 1 + ($unsigned($random(seed)) % 4);
                respAddr = seenReq.addr;
            end
        end
    end

    task automatic addOp(input int kind, input logic [31:0] addr, input logic [63:0] data,
                         input logic [7:0] mask, input logic [31:0] expValue);
        op_t op;
        op.kind     = kind[1:0];
        op.addr     = addr;
        op.data     = data;
        op.mask     = mask;
        op.expValue = expValue;
        ops.push_back(op);
    endtask

    task automatic applyOp(input op_t op);
        @(posedge clk);
        #1;
        case (op.kind)
            opRead: begin
                readReq      = 1'b1;
                readAddr.raw = op.addr;
            end
            opWrite: begin
                writeReq      = 1'b1;
                writeAddr.raw = op.addr;
                writeData     = op.data;
                writeMask     = op.mask;
            end
            opCsrWr: begin
                csrWrite = 1'b1;
                csrAddr  = op.addr[1:0];
                csrWdata = op.data[31:0];
            end
            default: begin
                csrAddr     = op.addr[1:0];
                csrCheck    = 1'b1;
                csrExpected = op.expValue;
            end
        endcase
        @(posedge clk);
        #1;
        readReq  = 1'b0;
        writeReq = 1'b0;
        csrWrite = 1'b0;
        csrCheck = 1'b0;
        csrAddr  = 2'd3;
        // a miss holds busy until its readValid
        while (busy) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        rst         = 1'b1;
        readReq     = 1'b0;
        readAddr    = '0;
        writeReq    = 1'b0;
        writeAddr   = '0;
        writeData   = '0;
        writeMask   = '0;
        csrWrite    = 1'b0;
        csrAddr     = 2'd3;
        csrWdata    = '0;
        csrCheck    = 1'b0;
        csrExpected = '0;

        // kind, address, data, mask, expected register value
        addOp(opRead,  32'h110, 0, 0, 0);
        addOp(opRead,  32'h110, 0, 0, 0);
        addOp(opCsrRd, 0, 0, 0, 0);
        addOp(opCsrWr, 0, 1, 0, 0);
        addOp(opCsrRd, 0, 0, 0, 1);
        addOp(opRead,  32'h110, 0, 0, 0);
        addOp(opRead,  32'h110, 0, 0, 0);
        // three lines in set 1 rotate through the round-robin victims
        addOp(opRead,  32'h08, 0, 0, 0);
        addOp(opRead,  32'h28, 0, 0, 0);
        addOp(opRead,  32'h48, 0, 0, 0);
        addOp(opRead,  32'h28, 0, 0, 0);
        addOp(opRead,  32'h08, 0, 0, 0);
        // write hit, then write to an evicted line
        addOp(opWrite, 32'h48, 64'h1111_2222_3333_4444, 8'h0f, 0);
        addOp(opRead,  32'h48, 0, 0, 0);
        addOp(opWrite, 32'h28, 64'haaaa_bbbb_cccc_dddd, 8'hf0, 0);
        addOp(opRead,  32'h28, 0, 0, 0);
        addOp(opCsrRd, 1, 0, 0, 3);
        addOp(opCsrRd, 2, 0, 0, 8);
        addOp(opCsrWr, 1, 0, 0, 0);
        addOp(opCsrRd, 1, 0, 0, 0);
        // enable and flush together
        addOp(opCsrWr, 0, 3, 0, 0);
        addOp(opCsrRd, 0, 0, 0, 1);
        addOp(opRead,  32'h110, 0, 0, 0);
        addOp(opRead,  32'h110, 0, 0, 0);
        addOp(opRead,  32'h28, 0, 0, 0);
        addOp(opCsrWr, 2, 0, 0, 0);
        addOp(opCsrRd, 2, 0, 0, 0);
        addOp(opCsrRd, 1, 0, 0, 1);
        // disabled reads go to memory even for a cached line
        addOp(opCsrWr, 0, 0, 0, 0);
        addOp(opRead,  32'h08, 0, 0, 0);
        addOp(opRead,  32'h110, 0, 0, 0);
        addOp(opCsrWr, 0, 1, 0, 0);
        addOp(opRead,  32'h08, 0, 0, 0);
        addOp(opRead,  32'h08, 0, 0, 0);
        addOp(opCsrRd, 2, 0, 0, 3);
        addOp(opCsrRd, 1, 0, 0, 2);
        cycleLimit = ops.size() * cyclesPerOp;

        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        foreach (ops[i]) begin
            applyOp(ops[i]);
        end
        repeat (4) @(posedge clk);
        #1;
        $display("%0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        @(posedge clk);
        while (cycles < cycleLimit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycleLimit);
        $display("%0d checks, %0d errors", checkCount, errorCount);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* list.f */
+incdir+verif
hw/cachePkg.sv
hw/cacheArray.sv
hw/cacheCtrl.sv
hw/cacheCsr.sv
hw/cacheTop.sv
verif/cacheChecker.sv
verif/cacheTb.sv

/* Bender.yml */
package:
  name: cache

sources:
  - files:
      - hw/cachePkg.sv
      - hw/cacheArray.sv
      - hw/cacheCtrl.sv
      - hw/cacheCsr.sv
      - hw/cacheTop.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/cacheChecker.sv
      - verif/cacheTb.sv
